// File: src.f
+incdir+include
design/afe_pkg.sv
design/afe_reset_ctrl.sv
design/adc_capture.sv
design/dac_mix.sv
design/dac_output.sv
design/analog_frontend.sv
test/analog_frontend_tb.sv

// File: test/analog_frontend_tb.sv
`timescale 1ns/10ps

`include "afe_consts.svh"

module analog_frontend_tb;

  import afe_pkg::*;

  localparam int MAG_MASK   = (1 << (`SAMPLE_W-1)) - 1;  // lower sample bits, 0x1FFF
  localparam int FULL_POS   = MAG_MASK;                  // +8191
  localparam int FULL_NEG   = -(MAG_MASK + 1);           // -8192
  localparam int WAIT_LIMIT = 20;                        // cycles per timed wait

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic      adc_clk;
  logic      rst_n_i;
  logic      pll_locked_i;
  logic      loop_en_i;
  adc_raw_t  adc_dat_a_i, adc_dat_b_i;
  sample_t   gen_a_i, gen_b_i, ctl_a_i, ctl_b_i;
  sample_t   adc_a_o, adc_b_o;
  dac_code_t dac_dat_a_o, dac_dat_b_o;
  logic      dac_rst_o;
  diag_cnt_t lock_loss_cnt_o;

  analog_frontend i_dut (
    .adc_clk         (adc_clk        ),
    .rst_n_i         (rst_n_i        ),
    .pll_locked_i    (pll_locked_i   ),
    .adc_dat_a_i     (adc_dat_a_i    ),
    .adc_dat_b_i     (adc_dat_b_i    ),
    .loop_en_i       (loop_en_i      ),
    .gen_a_i         (gen_a_i        ),
    .gen_b_i         (gen_b_i        ),
    .ctl_a_i         (ctl_a_i        ),
    .ctl_b_i         (ctl_b_i        ),
    .adc_a_o         (adc_a_o        ),
    .adc_b_o         (adc_b_o        ),
    .dac_dat_a_o     (dac_dat_a_o    ),
    .dac_dat_b_o     (dac_dat_b_o    ),
    .dac_rst_o       (dac_rst_o      ),
    .lock_loss_cnt_o (lock_loss_cnt_o)
  );

  // 20 ns adc_clk
  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;
  end

  //////////////////////////////
  // reference model state
  //////////////////////////////

  sample_t   exp_mix_a, exp_mix_b;   // first stage, saturated sums
  dac_code_t exp_dac_a, exp_dac_b;   // second stage, DAC codes
  sample_t   exp_adc_a, exp_adc_b;   // capture stage
  logic      exp_dac_rst;
  diag_cnt_t exp_cnt;
  logic      exp_stage_on;           // model of the stage reset, high = running
  int        locked_run;             // consecutive locked edges since reset or loss
  int        pos_clamps, neg_clamps; // saturation coverage

  //////////////////////////////
  // code rules
  //////////////////////////////

  // pad bits off, then flip the magnitude bits
  function automatic sample_t decode_adc_word(input adc_raw_t raw);
    return sample_t'((raw >> `ADC_PAD_BITS) ^ MAG_MASK);
  endfunction

  function automatic sample_t clamp_sum(input int sum);
    if (sum > FULL_POS) return sample_t'(FULL_POS);
    if (sum < FULL_NEG) return sample_t'(FULL_NEG);
    return sample_t'(sum);
  endfunction

  function automatic dac_code_t encode_dac_sample(input sample_t smp);
    return dac_code_t'(smp ^ MAG_MASK);   // sign kept, magnitude flipped
  endfunction

  // biased operand, full scale and near full scale often
  function automatic sample_t random_sample();
    int v;
    case ($urandom % 8)
      0:       v = FULL_POS;
      1:       v = FULL_NEG;
      2:       v = 4096 + int'($urandom % 4096);
      3:       v = FULL_NEG + int'($urandom % 4096);
      default: v = int'($urandom);
    endcase
    return sample_t'(v);
  endfunction

  //////////////////////////////
  // checks and failure
  //////////////////////////////

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
      stop_run();
    end
  endtask

  task automatic check_outputs();
    compare_value("adc_a_o", adc_a_o, exp_adc_a);
    compare_value("adc_b_o", adc_b_o, exp_adc_b);
    compare_value("dac_dat_a_o", dac_dat_a_o, exp_dac_a);
    compare_value("dac_dat_b_o", dac_dat_b_o, exp_dac_b);
    compare_value("dac_rst_o", dac_rst_o, exp_dac_rst);
    compare_value("lock_loss_cnt_o", lock_loss_cnt_o, exp_cnt);
  endtask

  //////////////////////////////
  // model update, once per edge
  //////////////////////////////

  // inputs are read at the edge, they only move 2 ns later
  task automatic update_model();
    logic    was_on;
    int      sum_a, sum_b;
    sample_t old_mix_a, old_mix_b;
    old_mix_a = exp_mix_a;
    old_mix_b = exp_mix_b;
    was_on    = exp_stage_on;
    if (!rst_n_i) begin
      locked_run = 0;
      exp_cnt    = '0;
    end else if (!pll_locked_i) begin
      locked_run = 0;
      exp_cnt    = exp_cnt + 1'b1;       // one per unlocked edge
    end else if (locked_run < `RST_SYNC_STAGES) begin
      locked_run++;
    end
    exp_stage_on = rst_n_i && (locked_run >= `RST_SYNC_STAGES);
    exp_dac_rst  = !(was_on && exp_stage_on);
    if (was_on && exp_stage_on) begin
      sum_a     = int'(gen_a_i) + int'(ctl_a_i);
      sum_b     = int'(gen_b_i) + int'(ctl_b_i);
      pos_clamps += (sum_a > FULL_POS) + (sum_b > FULL_POS);
      neg_clamps += (sum_a < FULL_NEG) + (sum_b < FULL_NEG);
      exp_mix_a = clamp_sum(sum_a);
      exp_mix_b = clamp_sum(sum_b);
      exp_dac_a = encode_dac_sample(old_mix_a);
      exp_dac_b = encode_dac_sample(old_mix_b);
      exp_adc_a = loop_en_i ? old_mix_a : decode_adc_word(adc_dat_a_i);
      exp_adc_b = loop_en_i ? old_mix_b : decode_adc_word(adc_dat_b_i);
    end else begin
      exp_mix_a = '0;                    // stages held in reset
      exp_mix_b = '0;
      exp_dac_a = encode_dac_sample('0);
      exp_dac_b = encode_dac_sample('0);
      exp_adc_a = '0;
      exp_adc_b = '0;
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // one edge, model, then check 2 ns later where outputs are settled
  task automatic step_cycle();
    @(posedge adc_clk);
    update_model();
    #2;
    check_outputs();
  endtask

  // loop_mode 0 off, 1 on, 2 random per cycle
  task automatic drive_random_inputs(input int loop_mode);
    adc_dat_a_i = adc_raw_t'($urandom);
    adc_dat_b_i = adc_raw_t'($urandom);
    gen_a_i     = random_sample();
    gen_b_i     = random_sample();
    ctl_a_i     = random_sample();
    ctl_b_i     = random_sample();
    loop_en_i   = (loop_mode == 2) ? $urandom % 2 : loop_mode[0];
  endtask

  task automatic run_traffic(input int cycles, input int loop_mode);
    repeat (cycles) begin
      drive_random_inputs(loop_mode);
      step_cycle();
    end
  endtask

  task automatic wait_dac_rst_release();
    int   i;
    logic seen;
    i    = 0;
    seen = 1'b0;
    while (!seen && i < WAIT_LIMIT) begin
      step_cycle();
      seen = (dac_rst_o === 1'b0);
      i++;
    end
    if (!seen) begin
      report_failure($sformatf("dac_rst_o stayed high for %0d cycles", WAIT_LIMIT));
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    int        n_low;
    diag_cnt_t cnt_before;
    rst_n_i      = 1'b0;
    pll_locked_i = 1'b1;
    loop_en_i    = 1'b0;
    adc_dat_a_i  = '0;
    adc_dat_b_i  = '0;
    gen_a_i      = '0;
    gen_b_i      = '0;
    ctl_a_i      = '0;
    ctl_b_i      = '0;
    exp_stage_on = 1'b0;
    exp_dac_rst  = 1'b1;
    exp_cnt      = '0;
    locked_run   = 0;
    pos_clamps   = 0;
    neg_clamps   = 0;
    void'($urandom(32'h0f558526));   // single seed for the whole run

    // board reset, 5 cycles, outputs parked
    repeat (5) begin
      step_cycle();
      compare_value("dac_rst_o", dac_rst_o, 1'b1);
      compare_value("dac_dat_a_o", dac_dat_a_o, 32'h1fff);
      compare_value("dac_dat_b_o", dac_dat_b_o, 32'h1fff);
      compare_value("adc_a_o", adc_a_o, 32'h0);
      compare_value("adc_b_o", adc_b_o, 32'h0);
    end
    rst_n_i = 1'b1;
    drive_random_inputs(0);
    wait_dac_rst_release();

    run_traffic(200, 0);   // ADC decode plus mix and encode
    run_traffic(200, 1);   // loopback
    run_traffic(100, 2);   // loopback switching

    // PLL loss, random length
    repeat (4) begin
      n_low        = 1 + int'($urandom % 20);
      cnt_before   = lock_loss_cnt_o;
      pll_locked_i = 1'b0;
      for (int i = 0; i < n_low; i++) begin
        drive_random_inputs(2);
        step_cycle();
        if (i == 0) compare_value("dac_rst_o", dac_rst_o, 1'b1);
      end
      pll_locked_i = 1'b1;
      compare_value("lock_loss_cnt_o delta", lock_loss_cnt_o - cnt_before, n_low);
      wait_dac_rst_release();
      run_traffic(60, 2);  // data back after relock
    end

    if (pos_clamps > 0 && neg_clamps > 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      report_failure($sformatf("saturation not covered, %0d positive and %0d negative clamps",
                               pos_clamps, neg_clamps));
    end
  end

endmodule : analog_frontend_tb

// File: design/analog_frontend.sv
`timescale 1ns/10ps

module analog_frontend (
  // clock, reset
  input  logic               adc_clk,          // ADC clock, all logic runs on it
  input  logic               rst_n_i,          // board reset, active low
  input  logic               pll_locked_i,     // PLL lock status
  // ADC
  input  afe_pkg::adc_raw_t  adc_dat_a_i,      // raw ADC, CH 1
  input  afe_pkg::adc_raw_t  adc_dat_b_i,      // raw ADC, CH 2
  input  logic               loop_en_i,        // DAC -> ADC digital loopback
  // DAC sources
  input  afe_pkg::sample_t   gen_a_i,          // generator, CH 1
  input  afe_pkg::sample_t   gen_b_i,          // generator, CH 2
  input  afe_pkg::sample_t   ctl_a_i,          // controller, CH 1
  input  afe_pkg::sample_t   ctl_b_i,          // controller, CH 2
  // to scope and controller
  output afe_pkg::sample_t   adc_a_o,
  output afe_pkg::sample_t   adc_b_o,
  // DAC pins, one parallel bus per channel
  output afe_pkg::dac_code_t dac_dat_a_o,
  output afe_pkg::dac_code_t dac_dat_b_o,
  output logic               dac_rst_o,
  // diagnostics
  output afe_pkg::diag_cnt_t lock_loss_cnt_o
);

  import afe_pkg::*;

  //////////////////////////////
  // local signals
  //////////////////////////////

  logic    afe_rst_n;        // stage reset, low while unlocked
  sample_t mix_a, mix_b;     // saturated sums, DAC and loopback

  //////////////////////////////
  // reset and clock health
  //////////////////////////////

  afe_reset_ctrl i_rst (
    .adc_clk         (adc_clk        ),
    .rst_n_i         (rst_n_i        ),
    .pll_locked_i    (pll_locked_i   ),
    .afe_rst_n_o     (afe_rst_n      ),
    .lock_loss_cnt_o (lock_loss_cnt_o)
  );

  //////////////////////////////
  // ADC capture
  //////////////////////////////

  adc_capture i_adc (
    .adc_clk     (adc_clk    ),
    .rst_n_i     (afe_rst_n  ),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (loop_en_i  ),
    .loop_a_i    (mix_a      ),  // previous cycle mix
    .loop_b_i    (mix_b      ),
    .adc_a_o     (adc_a_o    ),
    .adc_b_o     (adc_b_o    )
  );

  //////////////////////////////
  // DAC mixing
  //////////////////////////////

  dac_mix i_mix (
    .adc_clk (adc_clk  ),
    .rst_n_i (afe_rst_n),
    .gen_a_i (gen_a_i  ),
    .gen_b_i (gen_b_i  ),
    .ctl_a_i (ctl_a_i  ),
    .ctl_b_i (ctl_b_i  ),
    .mix_a_o (mix_a    ),
    .mix_b_o (mix_b    )
  );

  //////////////////////////////
  // DAC output
  //////////////////////////////

  dac_output i_dac (
    .adc_clk     (adc_clk    ),
    .rst_n_i     (afe_rst_n  ),
    .mix_a_i     (mix_a      ),
    .mix_b_i     (mix_b      ),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_rst_o   (dac_rst_o  )   // follows stage reset, one edge late
  );

endmodule : analog_frontend

// File: design/dac_output.sv
`timescale 1ns/10ps

`include "afe_consts.svh"

module dac_output (
  input  logic               adc_clk,       // ADC clock, DAC runs on it too
  input  logic               rst_n_i,       // stage reset, active low
  input  afe_pkg::sample_t   mix_a_i,       // mixed sample, CH 1
  input  afe_pkg::sample_t   mix_b_i,       // mixed sample, CH 2
  output afe_pkg::dac_code_t dac_dat_a_o,   // DAC code, CH 1
  output afe_pkg::dac_code_t dac_dat_b_o,   // DAC code, CH 2
  output logic               dac_rst_o      // DAC reset, active high
);

  import afe_pkg::*;

  //////////////////////////////
  // code conversion
  //////////////////////////////

  // code for a zero sample, 0x1FFF
  localparam dac_code_t DAC_IDLE = {1'b0, {(`SAMPLE_W-1){1'b1}}};

  // two's complement -> negative slope offset, inverse of the ADC rule
  function automatic dac_code_t dac_encode(input sample_t smp);
    return {smp[`SAMPLE_W-1], ~smp[`SAMPLE_W-2:0]};
  endfunction

  //////////////////////////////
  // output registers
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_dat_a_o <= DAC_IDLE;   // park at mid scale
      dac_dat_b_o <= DAC_IDLE;
    end else begin
      dac_dat_a_o <= dac_encode(mix_a_i);
      dac_dat_b_o <= dac_encode(mix_b_i);
    end
  end

  // reset strobe for the converter itself
  // high while in reset, low one edge after release
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_rst_o <= 1'b1;
    end else begin
      dac_rst_o <= 1'b0;
    end
  end

endmodule : dac_output

// File: design/dac_mix.sv
`timescale 1ns/10ps

`include "afe_consts.svh"

module dac_mix (
  input  logic             adc_clk,    // ADC clock
  input  logic             rst_n_i,    // stage reset, active low
  input  afe_pkg::sample_t gen_a_i,    // generator, CH 1
  input  afe_pkg::sample_t gen_b_i,    // generator, CH 2
  input  afe_pkg::sample_t ctl_a_i,    // controller, CH 1
  input  afe_pkg::sample_t ctl_b_i,    // controller, CH 2
  output afe_pkg::sample_t mix_a_o,    // saturated sum, CH 1
  output afe_pkg::sample_t mix_b_o     // saturated sum, CH 2
);

  import afe_pkg::*;

  //////////////////////////////
  // sum with one guard bit
  //////////////////////////////

  logic signed [`SAMPLE_W:0] sum_a, sum_b;   // one bit wider than a sample

  // explicit sign extension, no reliance on context sizing
  assign sum_a = {gen_a_i[`SAMPLE_W-1], gen_a_i} + {ctl_a_i[`SAMPLE_W-1], ctl_a_i};
  assign sum_b = {gen_b_i[`SAMPLE_W-1], gen_b_i} + {ctl_b_i[`SAMPLE_W-1], ctl_b_i};

  //////////////////////////////
  // saturation
  //////////////////////////////

  // top two bits differ -> result left the 14 bit range
  // clamp towards the sign of the wide sum
  function automatic sample_t saturate(input logic signed [`SAMPLE_W:0] sum);
    logic ovf;
    ovf = sum[`SAMPLE_W] ^ sum[`SAMPLE_W-1];
    if (ovf) begin
      return {sum[`SAMPLE_W], {(`SAMPLE_W-1){~sum[`SAMPLE_W]}}};  // +8191 / -8192
    end
    return sum[`SAMPLE_W-1:0];
  endfunction

  sample_t sat_a, sat_b;

  assign sat_a = saturate(sum_a);
  assign sat_b = saturate(sum_b);

  //////////////////////////////
  // output registers
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mix_a_o <= '0;
      mix_b_o <= '0;
    end else begin
      mix_a_o <= sat_a;      // also feeds loopback
      mix_b_o <= sat_b;
    end
  end

endmodule : dac_mix

// File: design/adc_capture.sv
`timescale 1ns/10ps

`include "afe_consts.svh"

module adc_capture (
  input  logic              adc_clk,       // ADC clock
  input  logic              rst_n_i,       // stage reset, active low
  input  afe_pkg::adc_raw_t adc_dat_a_i,   // raw ADC word, CH 1
  input  afe_pkg::adc_raw_t adc_dat_b_i,   // raw ADC word, CH 2
  input  logic              loop_en_i,     // digital loopback enable
  input  afe_pkg::sample_t  loop_a_i,      // DAC side sample, CH 1
  input  afe_pkg::sample_t  loop_b_i,      // DAC side sample, CH 2
  output afe_pkg::sample_t  adc_a_o,       // captured sample, CH 1
  output afe_pkg::sample_t  adc_b_o        // captured sample, CH 2
);

  import afe_pkg::*;

  //////////////////////////////
  // code conversion
  //////////////////////////////

  // drop pad bits, then negative slope offset -> two's complement
  // msb stays, the rest is inverted
  function automatic sample_t adc_decode(input adc_raw_t raw);
    logic [`SAMPLE_W-1:0] trim;
    trim = raw[`ADC_RAW_W-1:`ADC_PAD_BITS];
    return {trim[`SAMPLE_W-1], ~trim[`SAMPLE_W-2:0]};
  endfunction

  sample_t dec_a, dec_b;     // decoded converter samples
  sample_t sel_a, sel_b;     // after loopback select

  assign dec_a = adc_decode(adc_dat_a_i);
  assign dec_b = adc_decode(adc_dat_b_i);

  // loopback replaces the converter with the mixer output
  assign sel_a = loop_en_i ? loop_a_i : dec_a;
  assign sel_b = loop_en_i ? loop_b_i : dec_b;

  //////////////////////////////
  // capture registers
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;         // mid scale
      adc_b_o <= '0;
    end else begin
      adc_a_o <= sel_a;
      adc_b_o <= sel_b;
    end
  end

endmodule : adc_capture

// File: design/afe_reset_ctrl.sv
`timescale 1ns/10ps

`include "afe_consts.svh"

module afe_reset_ctrl (
  input  logic               adc_clk,          // ADC clock domain
  input  logic               rst_n_i,          // board reset, async, active low
  input  logic               pll_locked_i,     // PLL status, not yet synchronous
  output logic               afe_rst_n_o,      // reset for the datapath stages
  output afe_pkg::diag_cnt_t lock_loss_cnt_o   // unlocked cycles since board reset
);

  import afe_pkg::*;

  //////////////////////////////
  // stage reset
  //////////////////////////////

  // shift register of lock status
  // every stage is cleared as soon as lock is sampled low, so the
  // reset asserts on the very next edge instead of rippling through
  logic [`RST_SYNC_STAGES-1:0] sync_q;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;                               // hold stages in reset
    end else if (!pll_locked_i) begin
      sync_q <= '0;                               // lock lost, drop at once
    end else begin
      sync_q <= {sync_q[`RST_SYNC_STAGES-2:0], 1'b1};  // shift in lock
    end
  end

  // release after RST_SYNC_STAGES locked edges
  assign afe_rst_n_o = sync_q[`RST_SYNC_STAGES-1];

  //////////////////////////////
  // lock loss diagnostics
  //////////////////////////////

  // only board reset clears this one, a lock loss must stay visible
  // after the stages have come back up
  diag_cnt_t loss_cnt_q;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      loss_cnt_q <= '0;
    end else if (!pll_locked_i) begin
      loss_cnt_q <= loss_cnt_q + 1'b1;            // wraps at max
    end
  end

  assign lock_loss_cnt_o = loss_cnt_q;

endmodule : afe_reset_ctrl

// File: design/afe_pkg.sv
`include "afe_consts.svh"

package afe_pkg;

  //////////////////////////////
  // converter side codes
  //////////////////////////////

  // raw ADC word incl. pad bits
  typedef logic [`ADC_RAW_W-1:0] adc_raw_t;

  // DAC word, negative slope offset code
  // msb kept, lower bits inverted w.r.t. two's complement
  typedef logic [`SAMPLE_W-1:0] dac_code_t;

  //////////////////////////////
  // datapath samples
  //////////////////////////////

  // two's complement sample as seen by scope, generator, controller
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  //////////////////////////////
  // diagnostics
  //////////////////////////////

  // PLL lock loss count, cycles of adc_clk
  typedef logic [`DIAG_CNT_W-1:0] diag_cnt_t;

endpackage : afe_pkg

// File: include/afe_consts.svh
`ifndef AFE_CONSTS_SVH
`define AFE_CONSTS_SVH

//////////////////////////////
// ADC side
//////////////////////////////

// full converter word as it comes off the pins
`define ADC_RAW_W       16

// low bits reserved for the 16 bit part, always dropped
`define ADC_PAD_BITS    2

//////////////////////////////
// datapath
//////////////////////////////

// signed sample width, same for ADC and DAC
`define SAMPLE_W        14

//////////////////////////////
// reset and diagnostics
//////////////////////////////

// flops between PLL lock and stage reset release
`define RST_SYNC_STAGES 2

// unlocked cycle counter, wraps
`define DIAG_CNT_W      32

`endif
